//--- design/pool_pkg.sv
package pool_pkg;

  // pixel and pooled value width.
  localparam int DWIDTH  = 16;
  // size and position counters.
  localparam int LWIDTH  = 8;
  // largest square feature map, also the line buffer depth.
  localparam int MAX_FEA = 32;
  localparam int MWIDTH  = $clog2(MAX_FEA); // line buffer index.
  localparam int AWIDTH  = 4;                // apb address.
  // stages from a window's last pixel to its result.
  localparam int D_OUT   = 3;

  typedef enum logic [AWIDTH-1:0] {
    A_CTRL = 4'd0,
    A_FEA  = 4'd4,
    A_POOL = 4'd8,
    A_STAT = 4'd12
  } addr_e;

  typedef enum logic {
    S_WAIT,
    S_ACTIVE
  } state_e;

endpackage

//--- design/pool_apb_regs.sv
`timescale 1ns/1ns

module pool_apb_regs (
  input  logic                        clk,
  input  logic                        xrst,
  input  logic [pool_pkg::AWIDTH-1:0] paddr,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [31:0]                 pwdata,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  input  logic                        done,
  output logic                        start_pulse,
  output logic [pool_pkg::LWIDTH-1:0] fea_size,
  output logic [pool_pkg::LWIDTH-1:0] pool_size,
  output logic                        busy
);

  pool_pkg::state_e            r_state;
  logic [pool_pkg::LWIDTH-1:0] r_fea_cfg;
  logic [pool_pkg::LWIDTH-1:0] r_pool_cfg;
  logic                        r_done;
  logic                        r_pslverr;
  logic                        cfg_bad;
  logic                        setup_start;
  logic                        access_wr;
  logic                        start_ok;

  assign pready  = 1'b1; // no wait states.
  assign pslverr = r_pslverr;
  assign busy    = r_state == pool_pkg::S_ACTIVE;

  // start is judged in the setup phase, answered in the access phase.
  assign cfg_bad = busy
                || r_pool_cfg == '0
                || r_fea_cfg == '0
                || r_fea_cfg > pool_pkg::LWIDTH'(pool_pkg::MAX_FEA)
                || (r_fea_cfg % r_pool_cfg) != '0;
  assign setup_start = psel && !penable && pwrite && pwdata[0]
                    && paddr == pool_pkg::A_CTRL;
  assign access_wr   = psel && penable && pwrite;
  assign start_ok    = access_wr && pwdata[0] && paddr == pool_pkg::A_CTRL && !r_pslverr;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_pslverr <= 1'b0;
    end else if (psel && !penable) begin
      r_pslverr <= setup_start && cfg_bad;
    end else if (!psel) begin
      r_pslverr <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_fea_cfg  <= '0;
      r_pool_cfg <= '0;
    end else if (access_wr) begin
      if (paddr == pool_pkg::A_FEA)
        r_fea_cfg <= pwdata[pool_pkg::LWIDTH-1:0];
      if (paddr == pool_pkg::A_POOL)
        r_pool_cfg <= pwdata[pool_pkg::LWIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state     <= pool_pkg::S_WAIT;
      r_done      <= 1'b0;
      start_pulse <= 1'b0;
    end else begin
      start_pulse <= start_ok;
      if (start_ok) begin
        r_state <= pool_pkg::S_ACTIVE;
        r_done  <= 1'b0;
      end else if (done) begin
        r_state <= pool_pkg::S_WAIT;
        r_done  <= 1'b1; // sticky until next start.
      end
    end
  end

  // sizes frozen for the whole frame.
  always_ff @(posedge clk) begin
    if (start_ok) begin
      fea_size  <= r_fea_cfg;
      pool_size <= r_pool_cfg;
    end
  end

  always_comb begin
    case (paddr)
      pool_pkg::A_FEA:  prdata = 32'(r_fea_cfg);
      pool_pkg::A_POOL: prdata = 32'(r_pool_cfg);
      pool_pkg::A_STAT: prdata = {30'b0, r_done, busy};
      default:          prdata = '0;
    endcase
  end

  a_penable_psel: assert property (@(posedge clk) disable iff (!xrst) penable |-> psel);
  // the frame end only comes back for an accepted start.
  a_done_busy: assert property (@(posedge clk) disable iff (!xrst) done |-> busy);

endmodule

//--- design/pool_ctrl.sv
`timescale 1ns/1ns

module pool_ctrl (
  input  logic                        clk,
  input  logic                        xrst,
  input  logic                        start_pulse,
  input  logic [pool_pkg::LWIDTH-1:0] fea_size,
  input  logic [pool_pkg::LWIDTH-1:0] pool_size,
  input  logic                        in_valid,
  output logic                        first_col,
  output logic                        last_col,
  output logic                        first_row,
  output logic                        win_done,
  output logic [pool_pkg::LWIDTH-1:0] col_idx,
  output logic                        out_start,
  output logic                        out_valid,
  output logic                        out_stop,
  output logic                        done
);

  pool_pkg::state_e            r_state;
  logic [pool_pkg::LWIDTH-1:0] r_x;
  logic [pool_pkg::LWIDTH-1:0] r_y;
  logic [pool_pkg::LWIDTH-1:0] r_wx;
  logic [pool_pkg::LWIDTH-1:0] r_wy;
  logic [pool_pkg::LWIDTH-1:0] r_ox;
  logic [pool_pkg::D_OUT-1:0]  r_start_sr;
  logic [pool_pkg::D_OUT-1:0]  r_valid_sr;
  logic [pool_pkg::D_OUT-1:0]  r_stop_sr;
  logic                        take;
  logic                        x_last;
  logic                        y_last;
  logic                        wx_last;
  logic                        wy_last;
  logic                        mark_valid;
  logic                        mark_start;
  logic                        mark_stop;

  assign take    = r_state == pool_pkg::S_ACTIVE && in_valid;
  assign x_last  = r_x == fea_size - 1'b1;
  assign y_last  = r_y == fea_size - 1'b1;
  assign wx_last = r_wx == pool_size - 1'b1;
  assign wy_last = r_wy == pool_size - 1'b1;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state <= pool_pkg::S_WAIT;
    end else begin
      case (r_state)
        pool_pkg::S_WAIT:
          if (start_pulse)
            r_state <= pool_pkg::S_ACTIVE;
        pool_pkg::S_ACTIVE:
          if (out_stop)
            r_state <= pool_pkg::S_WAIT;
        default:
          r_state <= pool_pkg::S_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst || r_state == pool_pkg::S_WAIT) begin
      r_x  <= '0;
      r_y  <= '0;
      r_wx <= '0;
      r_wy <= '0;
      r_ox <= '0;
    end else if (take) begin
      if (wx_last) begin
        r_wx <= '0;
        r_ox <= r_ox + 1'b1;
      end else begin
        r_wx <= r_wx + 1'b1;
      end
      if (x_last) begin // a row end is also a window end.
        r_x  <= '0;
        r_ox <= '0;
        r_y  <= y_last ? '0 : r_y + 1'b1;
        r_wy <= wy_last ? '0 : r_wy + 1'b1;
      end else begin
        r_x <= r_x + 1'b1;
      end
    end
  end

  // flags line up with the pixel registered in pool_row_max.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      first_col <= 1'b0;
      last_col  <= 1'b0;
      first_row <= 1'b0;
      win_done  <= 1'b0;
      col_idx   <= '0;
    end else begin
      first_col <= take && r_wx == '0;
      last_col  <= take && wx_last;
      first_row <= take && r_wy == '0;
      win_done  <= take && wx_last && wy_last;
      col_idx   <= r_ox;
    end
  end

  assign mark_valid = take && wx_last && wy_last;
  assign mark_start = mark_valid && r_x == pool_size - 1'b1 && r_y == pool_size - 1'b1;
  assign mark_stop  = take && x_last && y_last;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_start_sr <= '0;
      r_valid_sr <= '0;
      r_stop_sr  <= '0;
    end else begin
      r_start_sr <= {r_start_sr[pool_pkg::D_OUT-2:0], mark_start};
      r_valid_sr <= {r_valid_sr[pool_pkg::D_OUT-2:0], mark_valid};
      r_stop_sr  <= {r_stop_sr[pool_pkg::D_OUT-2:0], mark_stop};
    end
  end

  assign out_start = r_start_sr[pool_pkg::D_OUT-1];
  assign out_valid = r_valid_sr[pool_pkg::D_OUT-1];
  assign out_stop  = r_stop_sr[pool_pkg::D_OUT-1];
  assign done      = out_stop;

  a_no_idle_pixel: assert property (@(posedge clk) disable iff (!xrst)
    in_valid |-> r_state != pool_pkg::S_WAIT);
  a_stop_valid: assert property (@(posedge clk) disable iff (!xrst)
    out_stop |-> out_valid);

endmodule

//--- design/pool_row_max.sv
`timescale 1ns/1ns

module pool_row_max (
  input  logic                               clk,
  input  logic                               xrst,
  input  logic                               in_valid,
  input  logic signed [pool_pkg::DWIDTH-1:0] in_data,
  input  logic                               first_col,
  input  logic                               last_col,
  output logic                               row_max_valid,
  output logic signed [pool_pkg::DWIDTH-1:0] row_max
);

  logic                               r_valid;
  logic signed [pool_pkg::DWIDTH-1:0] r_data;
  logic signed [pool_pkg::DWIDTH-1:0] r_max;
  logic signed [pool_pkg::DWIDTH-1:0] cur_max;

  // stage 1, same edge as the ctrl flags.
  always_ff @(posedge clk) begin
    if (!xrst)
      r_valid <= 1'b0;
    else
      r_valid <= in_valid;
  end

  always_ff @(posedge clk) begin
    r_data <= in_data;
  end

  // restart at the window's left edge.
  always_comb begin
    if (first_col || r_data > r_max)
      cur_max = r_data;
    else
      cur_max = r_max;
  end

  // stage 2.
  always_ff @(posedge clk) begin
    if (r_valid)
      r_max <= cur_max;
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      row_max_valid <= 1'b0;
    else
      row_max_valid <= r_valid && last_col;
  end

  assign row_max = r_max; // holds until the next valid pixel.

endmodule

//--- design/pool_line_buf.sv
`timescale 1ns/1ns

module pool_line_buf (
  input  logic                               clk,
  input  logic                               xrst,
  input  logic                               row_max_valid,
  input  logic signed [pool_pkg::DWIDTH-1:0] row_max,
  input  logic        [pool_pkg::LWIDTH-1:0] col_idx,
  input  logic                               first_row,
  input  logic                               win_done,
  output logic signed [pool_pkg::DWIDTH-1:0] out_data
);

  // partial column maxima of the current row band.
  logic signed [pool_pkg::DWIDTH-1:0] mem [pool_pkg::MAX_FEA];
  logic        [pool_pkg::MWIDTH-1:0] r_col;
  logic                               r_first_row;
  logic                               r_win_done;
  logic signed [pool_pkg::DWIDTH-1:0] stored;
  logic signed [pool_pkg::DWIDTH-1:0] merged;

  // flags arrive one stage ahead of row_max.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_first_row <= 1'b0;
      r_win_done  <= 1'b0;
    end else begin
      r_first_row <= first_row;
      r_win_done  <= win_done;
    end
  end

  always_ff @(posedge clk) begin
    r_col <= col_idx[pool_pkg::MWIDTH-1:0];
  end

  assign stored = mem[r_col];

  always_comb begin
    if (r_first_row || row_max > stored)
      merged = row_max; // first row of a band overwrites.
    else
      merged = stored;
  end

  always_ff @(posedge clk) begin
    if (row_max_valid)
      mem[r_col] <= merged;
  end

  // stage 3.
  always_ff @(posedge clk) begin
    if (r_win_done)
      out_data <= merged;
  end

  // a window only closes on a row maximum.
  a_done_has_row: assert property (@(posedge clk) disable iff (!xrst)
    r_win_done |-> row_max_valid);

endmodule

//--- design/pool_top.sv
`timescale 1ns/1ns

module pool_top (
  input  logic                               clk,
  input  logic                               xrst,
  input  logic        [pool_pkg::AWIDTH-1:0] paddr,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic        [31:0]                 pwdata,
  output logic        [31:0]                 prdata,
  output logic                               pready,
  output logic                               pslverr,
  input  logic                               in_valid,
  input  logic signed [pool_pkg::DWIDTH-1:0] in_data,
  output logic                               out_start,
  output logic                               out_valid,
  output logic                               out_stop,
  output logic signed [pool_pkg::DWIDTH-1:0] out_data
);

  logic                               start_pulse;
  logic                               done;
  logic                               busy;
  logic        [pool_pkg::LWIDTH-1:0] fea_size;
  logic        [pool_pkg::LWIDTH-1:0] pool_size;
  logic                               first_col;
  logic                               last_col;
  logic                               first_row;
  logic                               win_done;
  logic        [pool_pkg::LWIDTH-1:0] col_idx;
  logic                               row_max_valid;
  logic signed [pool_pkg::DWIDTH-1:0] row_max;

  pool_apb_regs i_regs (
    .clk, .xrst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .done, .start_pulse, .fea_size, .pool_size, .busy
  );

  pool_ctrl i_ctrl (
    .clk, .xrst, .start_pulse, .fea_size, .pool_size, .in_valid,
    .first_col, .last_col, .first_row, .win_done, .col_idx,
    .out_start, .out_valid, .out_stop, .done
  );

  pool_row_max i_row_max (
    .clk, .xrst, .in_valid, .in_data, .first_col, .last_col, .row_max_valid, .row_max
  );

  pool_line_buf i_line_buf (
    .clk, .xrst, .row_max_valid, .row_max, .col_idx, .first_row, .win_done, .out_data
  );

  // frames only run while the register block reports busy.
  a_out_busy: assert property (@(posedge clk) disable iff (!xrst) out_valid |-> busy);

endmodule

//--- sim/tb_pool_top.sv
`timescale 1ns/1ns

module tb_pool_top;

  localparam int NCASE   = 10;
  localparam int MAX_GAP = 3;    // idle cycles before a pixel, at most.
  localparam int NPIX    = 8192; // pixel slots over the whole run.

  // fea_size, pool_size, random gaps, expected pslverr on start.
  int t_fea  [NCASE] = '{8, 12, 16, 4, 32, 12, 8, 10, 40, 32};
  int t_pool [NCASE] = '{2, 3, 4, 1, 2, 3, 0, 3, 4, 2};
  int t_gap  [NCASE] = '{0, 0, 0, 0, 0, 1, 0, 0, 0, 1};
  int t_err  [NCASE] = '{0, 0, 0, 0, 0, 0, 1, 1, 1, 0};

  logic                               clk;
  logic                               xrst;
  logic        [pool_pkg::AWIDTH-1:0] paddr;
  logic                               psel;
  logic                               penable;
  logic                               pwrite;
  logic        [31:0]                 pwdata;
  logic        [31:0]                 prdata;
  logic                               pready;
  logic                               pslverr;
  logic                               in_valid;
  logic signed [pool_pkg::DWIDTH-1:0] in_data;
  logic                               out_start;
  logic                               out_valid;
  logic                               out_stop;
  logic signed [pool_pkg::DWIDTH-1:0] out_data;

  logic [31:0] seed = 32'h207a5793;
  logic signed [pool_pkg::DWIDTH-1:0] frame [pool_pkg::MAX_FEA*pool_pkg::MAX_FEA];
  int exp_val[$];
  int exp_pix[$]; // global index of the window's last pixel.
  int exp_first[$];
  int exp_last[$];
  int pix_cyc [NPIX];
  int cyc      = 0;
  int pix_seen = 0;
  int pix_base = 0;
  int out_seen = 0;

  pool_top i_dut (
    .clk, .xrst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .in_valid, .in_data, .out_start, .out_valid, .out_stop, .out_data
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic signed [31:0] got,
                             input logic signed [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("Fail time=%0t signal=%s got=%0d expected=%0d",
                          $time, name, got, exp));
  endtask

  task automatic apb_write(input pool_pkg::addr_e addr, input logic [31:0] data,
                           output logic err);
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= 1'b1;
    pwdata  <= data;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    check_value("pready", pready, 1); // no wait states.
    err = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input pool_pkg::addr_e addr, output logic [31:0] data);
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    check_value("pready", pready, 1);
    data = prdata;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // random frame plus the expected window maxima in raster order.
  task automatic build_frame(input int f, input int p);
    int nw;
    int m;
    int v;
    nw = f / p;
    for (int k = 0; k < f * f; k++)
      frame[k] = lcg_next() >> 16;
    for (int wy = 0; wy < nw; wy++) begin
      for (int wx = 0; wx < nw; wx++) begin
        m = frame[wy * p * f + wx * p];
        for (int dy = 0; dy < p; dy++) begin
          for (int dx = 0; dx < p; dx++) begin
            v = frame[(wy * p + dy) * f + wx * p + dx];
            if (v > m)
              m = v;
          end
        end
        exp_val.push_back(m);
        exp_pix.push_back(pix_base + (wy * p + p - 1) * f + wx * p + p - 1);
        exp_first.push_back(wy == 0 && wx == 0);
        exp_last.push_back(wy == nw - 1 && wx == nw - 1);
      end
    end
  endtask

  task automatic send_frame(input int f, input int gaps);
    int gap;
    for (int k = 0; k < f * f; k++) begin
      gap = gaps ? int'(lcg_next() >> 30) : 0;
      repeat (gap) begin
        @(posedge clk);
        in_valid <= 1'b0;
        in_data  <= lcg_next() >> 16; // junk, must be ignored.
      end
      @(posedge clk);
      in_valid <= 1'b1;
      in_data  <= frame[k];
    end
    @(posedge clk);
    in_valid <= 1'b0;
    pix_base += f * f;
  endtask

  // outputs checked at the sampling edge, latency counted in edges.
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (in_valid === 1'b1) begin
      pix_cyc[pix_seen] = cyc;
      pix_seen++;
    end
    if (out_valid === 1'b1) begin
      if (exp_val.size() == 0)
        abort_run($sformatf("unexpected output at time %0t with no window pending", $time));
      check_value("out_data", out_data, exp_val.pop_front());
      check_value("out_start", out_start, exp_first.pop_front());
      check_value("out_stop", out_stop, exp_last.pop_front());
      check_value("out_latency", cyc - pix_cyc[exp_pix.pop_front()], pool_pkg::D_OUT);
      out_seen++;
    end else if (xrst === 1'b1) begin
      check_value("out_start", out_start, 0); // framing marks only with a result.
      check_value("out_stop", out_stop, 0);
    end
  end

  initial begin
    int total;
    int limit;
    total = 0;
    for (int i = 0; i < NCASE; i++)
      total += t_fea[i] * t_fea[i];
    limit = (total * (MAX_GAP + 1) + NCASE * 400) * 10;
    #(limit);
    abort_run($sformatf("timeout, the test did not finish within %0d ns", limit));
  end

  initial begin
    logic [31:0] rd;
    logic        err;
    int          seen0;
    int          nwin;
    clk      = 1'b0;
    xrst     <= 1'b0;
    paddr    <= '0;
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    pwdata   <= '0;
    in_valid <= 1'b0;
    in_data  <= '0;
    repeat (4) @(posedge clk);
    xrst <= 1'b1;

    for (int i = 0; i < NCASE; i++) begin
      apb_write(pool_pkg::A_FEA, t_fea[i], err);
      check_value("pslverr", err, 0);
      apb_write(pool_pkg::A_POOL, t_pool[i], err);
      check_value("pslverr", err, 0);
      apb_read(pool_pkg::A_FEA, rd);
      check_value("prdata_fea", rd, t_fea[i]);
      apb_read(pool_pkg::A_POOL, rd);
      check_value("prdata_pool", rd, t_pool[i]);
      if (t_err[i] == 0)
        build_frame(t_fea[i], t_pool[i]);
      seen0 = out_seen;

      apb_write(pool_pkg::A_CTRL, 32'h1, err);
      check_value("pslverr", err, t_err[i]);
      apb_read(pool_pkg::A_STAT, rd);
      check_value("stat_busy", rd[0], t_err[i] == 0);

      if (t_err[i] != 0) begin
        // refused start, nothing may come out.
        repeat (2 * pool_pkg::D_OUT + 4) @(posedge clk);
        check_value("out_count", out_seen - seen0, 0);
        apb_read(pool_pkg::A_STAT, rd);
        check_value("stat_busy", rd[0], 0);
      end else begin
        check_value("stat_done", rd[1], 0);
        send_frame(t_fea[i], t_gap[i]);
        rd = '0;
        while (rd[1] == 1'b0)
          apb_read(pool_pkg::A_STAT, rd);
        check_value("stat_busy", rd[0], 0);
        nwin = (t_fea[i] / t_pool[i]) * (t_fea[i] / t_pool[i]);
        check_value("out_count", out_seen - seen0, nwin);
        check_value("pending_windows", exp_val.size(), 0);
      end
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- src.f
design/pool_pkg.sv
design/pool_apb_regs.sv
design/pool_ctrl.sv
design/pool_row_max.sv
design/pool_line_buf.sv
design/pool_top.sv
sim/tb_pool_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_pool_top
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
